//--- src/uopPkg.sv
`default_nettype none

package uopPkg;

  // ------------------------------------------------------------
  // Widths and register numbers
  // ------------------------------------------------------------
  localparam int unsigned instrWidth = 32;     // ARM instruction word
  localparam int unsigned regCount   = 16;     // Architectural registers r0..r15
  localparam logic [3:0]  rzIndex    = 4'd15;  // Scratch Rz, field value with regFileRz set
  localparam logic [3:0]  lrIndex    = 4'd14;  // Link register
  localparam logic [3:0]  pcIndex    = 4'd15;  // Program counter
  localparam int unsigned wordBytes  = 4;      // Address step per transferred word

  // ------------------------------------------------------------
  // Instruction field positions
  // ------------------------------------------------------------
  localparam int unsigned condLsb = 28;  // Condition code
  localparam int unsigned rnLsb   = 16;  // Base / first operand
  localparam int unsigned rdLsb   = 12;  // Destination
  localparam int unsigned rmLsb   = 0;   // Second operand register

  localparam int unsigned bitP = 24;  // Pre-index
  localparam int unsigned bitU = 23;  // Up / down
  localparam int unsigned bitB = 22;  // Byte for SWP, user bank for LDM/STM
  localparam int unsigned bitW = 21;  // Base writeback
  localparam int unsigned bitL = 20;  // Load / store
  localparam int unsigned bitS = 20;  // Set flags for data processing

  // Instruction class seen in the ready state
  typedef enum logic [2:0] {
    kindPlain,  // Passes through untouched
    kindRsr,    // Register-shifted-register data processing
    kindBl,     // Branch with link
    kindSwp,    // SWP / SWPB
    kindBlock   // LDM / STM with a non-empty list
  } uopKind_e;

  // Sequencer states, one per step after the first
  typedef enum logic [2:0] {
    stReady,     // First step of any instruction
    stRsr,       // RSR operation on Rz
    stBl,        // Branch without link
    stSwpStore,  // SWP store of Rm
    stSwpMove,   // SWP move of Rz to Rd
    stBlock,     // One register transfer per cycle
    stBlockWb    // Base register update
  } seqState_e;

  // Fields sliced from the instruction in decode
  typedef struct packed {
    logic [3:0]          cond;
    logic [3:0]          rn;
    logic [3:0]          rd;
    logic [3:0]          rm;
    logic                p;
    logic                u;
    logic                s;
    logic                w;
    logic                l;
    logic                b;
    logic                usr;       // Bit 22 of a block transfer
    logic [regCount-1:0] regList;   // LDM/STM register list
    logic [4:0]          regTotal;  // Ones in regList
  } instrFields_t;

  // Control outputs to the decode stage
  typedef struct packed {
    logic       instrMux;       // Use uopInstr instead of the fetched word
    logic       uopStall;       // Hold decode on this instruction
    logic       ldmStmForward;  // Block transfer step in flight
    logic       regUsr;         // Use the user register bank
    logic       cpsrRestore;    // Restore CPSR from SPSR on load of r15
    logic       prevRsr;        // Second RSR step
    logic [2:0] regFileRz;      // Rz select for write, read 2, read 1
  } uopCtrl_t;

endpackage

`default_nettype wire

//--- src/instrClassifier.sv
`timescale 1ns/1ps
`default_nettype none

module instrClassifier (
  input  wire logic [uopPkg::instrWidth-1:0] instr,
  output uopPkg::uopKind_e                   kind,
  output uopPkg::instrFields_t               fields
);

  logic       isSwp;     // SWP/SWPB encoding
  logic       isRsr;     // Data processing with register shift amount
  logic       isBlock;   // LDM/STM with something to transfer
  logic       isBl;      // Branch with link
  logic [4:0] ones;      // Register list population count

  // ------------------------------------------------------------
  // Class recognition
  // ------------------------------------------------------------
  assign isSwp = (instr[27:23] == 5'b00010) && (instr[21:20] == 2'b00)
               && (instr[7:4] == 4'b1001);

  // Opcode 10xx without S is the miscellaneous space, not RSR
  assign isRsr = (instr[27:25] == 3'b000) && !instr[7] && instr[4]
               && !((instr[24:23] == 2'b10) && !instr[uopPkg::bitS]);

  assign isBlock = (instr[27:25] == 3'b100) && (ones != 5'd0);  // Empty list stays plain
  assign isBl    = (instr[27:24] == 4'b1011);

  always_comb begin
    ones = '0;
    for (int i = 0; i < uopPkg::regCount; i++) begin
      ones = ones + 5'(instr[i]);
    end
  end

  always_comb begin
    if (isSwp) kind = uopPkg::kindSwp;            // Priority as listed
    else if (isRsr) kind = uopPkg::kindRsr;
    else if (isBlock) kind = uopPkg::kindBlock;
    else if (isBl) kind = uopPkg::kindBl;
    else kind = uopPkg::kindPlain;
  end

  // ------------------------------------------------------------
  // Field slicing
  // ------------------------------------------------------------
  always_comb begin
    fields.cond     = instr[uopPkg::condLsb +: 4];
    fields.rn       = instr[uopPkg::rnLsb +: 4];
    fields.rd       = instr[uopPkg::rdLsb +: 4];
    fields.rm       = instr[uopPkg::rmLsb +: 4];
    fields.p        = instr[uopPkg::bitP];
    fields.u        = instr[uopPkg::bitU];
    fields.s        = instr[uopPkg::bitS];
    fields.w        = instr[uopPkg::bitW];
    fields.l        = instr[uopPkg::bitL];
    fields.b        = instr[uopPkg::bitB];
    fields.usr      = instr[uopPkg::bitB];      // Same bit, block transfer meaning
    fields.regList  = instr[uopPkg::regCount-1:0];
    fields.regTotal = ones;
  end

endmodule

`default_nettype wire

//--- src/regListWalker.sv
`timescale 1ns/1ps
`default_nettype none

module regListWalker (
  input  wire logic                        clk,
  input  wire logic                        reset,
  input  wire logic [uopPkg::regCount-1:0] regList,
  input  wire logic                        listLoad,
  input  wire logic                        listAdvance,
  output logic      [3:0]                  curReg,
  output logic                             lastReg
);

  logic [uopPkg::regCount-1:0] remList;    // Registers still to transfer
  logic [uopPkg::regCount-1:0] dropLowest; // remList without its lowest one

  // ------------------------------------------------------------
  // Remaining list register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      remList <= '0;
    end else if (listLoad) begin
      remList <= regList;               // Fresh list from the instruction
    end else if (listAdvance) begin
      remList <= dropLowest;            // One register done
    end
  end

  assign dropLowest = remList & (remList - 1'b1);  // Clears lowest set bit

  // Only one bit left means this is the final transfer
  assign lastReg = (remList != '0) && (dropLowest == '0);

  // ------------------------------------------------------------
  // Lowest set bit, so registers go out in ascending order
  // ------------------------------------------------------------
  always_comb begin
    curReg = '0;
    for (int i = uopPkg::regCount - 1; i >= 0; i--) begin
      if (remList[i]) begin
        curReg = 4'(i);               // Lower index overwrites higher
      end
    end
  end

endmodule

`default_nettype wire

//--- src/uopSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module uopSequencer (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 stall,
  input  wire logic                 exceptionSavePC,
  input  uopPkg::uopKind_e          kind,
  input  uopPkg::instrFields_t      fields,
  input  wire logic                 lastReg,
  output uopPkg::seqState_e         state,
  output logic                      listLoad,
  output logic                      listAdvance
);

  uopPkg::seqState_e nextState;  // Mealy next state
  logic              startBlock; // LDM/STM begins this cycle

  // ------------------------------------------------------------
  // State register, frozen by the external stall
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= uopPkg::stReady;
    end else if (!stall) begin
      state <= nextState;
    end
  end

  // ------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------
  always_comb begin
    nextState = uopPkg::stReady;
    case (state)
      uopPkg::stReady: begin
        if (exceptionSavePC) begin
          nextState = uopPkg::stReady;         // Single injected MOV
        end else begin
          case (kind)
            uopPkg::kindRsr:   nextState = uopPkg::stRsr;
            uopPkg::kindBl:    nextState = uopPkg::stBl;
            uopPkg::kindSwp:   nextState = uopPkg::stSwpStore;
            uopPkg::kindBlock: nextState = uopPkg::stBlock;
            default:           nextState = uopPkg::stReady;  // Plain pass-through
          endcase
        end
      end
      uopPkg::stRsr:      nextState = uopPkg::stReady;
      uopPkg::stBl:       nextState = uopPkg::stReady;
      uopPkg::stSwpStore: nextState = uopPkg::stSwpMove;
      uopPkg::stSwpMove:  nextState = uopPkg::stReady;
      uopPkg::stBlock: begin
        if (!lastReg) begin
          nextState = uopPkg::stBlock;         // More registers to go
        end else if (fields.w) begin
          nextState = uopPkg::stBlockWb;       // Base update still owed
        end else begin
          nextState = uopPkg::stReady;
        end
      end
      uopPkg::stBlockWb:  nextState = uopPkg::stReady;
      default:            nextState = uopPkg::stReady;
    endcase
  end

  // ------------------------------------------------------------
  // Walker controls
  // ------------------------------------------------------------
  assign startBlock = (state == uopPkg::stReady) && !exceptionSavePC
                    && (kind == uopPkg::kindBlock);

  assign listLoad    = !stall && startBlock;                  // Latch list with the SUB step
  assign listAdvance = !stall && (state == uopPkg::stBlock);  // One transfer issued

endmodule

`default_nettype wire

//--- src/uopEncoder.sv
`timescale 1ns/1ps
`default_nettype none

module uopEncoder (
  input  uopPkg::seqState_e                  state,
  input  uopPkg::uopKind_e                   kind,
  input  uopPkg::instrFields_t               fields,
  input  wire logic [3:0]                    curReg,
  input  wire logic                          lastReg,
  input  wire logic                          exceptionSavePC,
  input  wire logic [uopPkg::instrWidth-1:0] instr,
  output logic      [uopPkg::instrWidth-1:0] uopInstr,
  output uopPkg::uopCtrl_t                   ctrl
);

  logic [7:0] fourN;     // Register count times four
  logic [7:0] startImm;  // Offset to one word below the lowest address

  assign fourN = {1'b0, fields.regTotal, 2'b00};

  always_comb begin
    case ({fields.p, fields.u})
      2'b00:   startImm = fourN;                       // DA
      2'b01:   startImm = 8'(uopPkg::wordBytes);       // IA
      2'b10:   startImm = fourN + 8'(uopPkg::wordBytes); // DB
      default: startImm = 8'd0;                        // IB
    endcase
  end

  // ------------------------------------------------------------
  // Step word and controls
  // ------------------------------------------------------------
  always_comb begin
    uopInstr = instr;                // Plain instruction passes through
    ctrl     = '0;
    case (state)
      uopPkg::stReady: begin
        if (exceptionSavePC) begin
          ctrl.instrMux = 1'b1;
          // mov r14, r15 under AL
          uopInstr = {4'b1110, 3'b000, 4'b1101, 1'b0, 4'b0000, uopPkg::lrIndex,
                      8'd0, uopPkg::pcIndex};
        end else if (kind != uopPkg::kindPlain) begin
          ctrl.instrMux = 1'b1;
          ctrl.uopStall = 1'b1;      // Every complex first step stalls decode
          case (kind)
            uopPkg::kindRsr: begin
              ctrl.regFileRz = 3'b101;  // Write Rz, shift amount on read 1
              uopInstr = {instr[31:25], 4'b1101, 1'b0, 4'b0000, uopPkg::rzIndex,
                          instr[11:0]};  // MOV Rz, shifter operand
            end
            uopPkg::kindBl: begin
              uopInstr = {fields.cond, 3'b001, 4'b0010, 1'b0, uopPkg::pcIndex,
                          uopPkg::lrIndex, 4'b0000, 8'(uopPkg::wordBytes)};  // SUB r14, r15, #4
            end
            uopPkg::kindSwp: begin
              ctrl.regFileRz = 3'b100;  // Load lands in Rz
              uopInstr = {fields.cond, 5'b01011, fields.b, 2'b01, fields.rn,
                          uopPkg::rzIndex, 12'd0};
            end
            default: begin              // Block transfer start address
              ctrl.regFileRz = 3'b100;
              uopInstr = {fields.cond, 3'b001, 4'b0010, 1'b0, fields.rn,
                          uopPkg::rzIndex, 4'b0000, startImm};  // SUB Rz, Rn, #start
            end
          endcase
        end
      end
      uopPkg::stRsr: begin
        ctrl.instrMux  = 1'b1;
        ctrl.prevRsr   = 1'b1;
        ctrl.regFileRz = 3'b010;     // Rz as unshifted Rm
        uopInstr = {instr[31:12], 8'd0, uopPkg::rzIndex};
      end
      uopPkg::stBl: begin
        ctrl.instrMux = 1'b1;
        uopInstr = {instr[31:25], 1'b0, instr[23:0]};  // Link bit cleared
      end
      uopPkg::stSwpStore: begin
        ctrl.instrMux = 1'b1;
        ctrl.uopStall = 1'b1;
        uopInstr = {fields.cond, 5'b01011, fields.b, 2'b00, fields.rn, fields.rm, 12'd0};
      end
      uopPkg::stSwpMove: begin
        ctrl.instrMux  = 1'b1;
        ctrl.regFileRz = 3'b010;
        uopInstr = {fields.cond, 3'b000, 4'b1101, 1'b0, 4'b0000, fields.rd,
                    8'd0, uopPkg::rzIndex};  // MOV Rd, Rz
      end
      uopPkg::stBlock: begin
        ctrl.instrMux      = 1'b1;
        ctrl.uopStall      = !(lastReg && !fields.w);  // Last step only without writeback
        ctrl.ldmStmForward = 1'b1;
        ctrl.regFileRz     = 3'b001;  // Rz is the base
        ctrl.regUsr        = fields.usr && (!fields.l || !fields.regList[uopPkg::pcIndex]);
        ctrl.cpsrRestore   = fields.usr && fields.l && (curReg == uopPkg::pcIndex);
        // LDR/STR curReg, [Rz, #4]!
        uopInstr = {fields.cond, 3'b010, 1'b1, 1'b1, 1'b0, 1'b1, fields.l,
                    uopPkg::rzIndex, curReg, 12'(uopPkg::wordBytes)};
      end
      uopPkg::stBlockWb: begin
        ctrl.instrMux = 1'b1;
        // ADD or SUB Rn, Rn, #4N by the U bit
        uopInstr = {fields.cond, 3'b001, 1'b0, fields.u, !fields.u, 2'b00,
                    fields.rn, fields.rn, 4'b0000, fourN};
      end
      default: begin
        uopInstr = instr;
        ctrl     = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/microOpUnit.sv
`timescale 1ns/1ps
`default_nettype none

module microOpUnit (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic [uopPkg::instrWidth-1:0] instr,
  input  wire logic                          stall,
  input  wire logic                          exceptionSavePC,
  output logic      [uopPkg::instrWidth-1:0] uopInstr,
  output uopPkg::uopCtrl_t                   ctrl
);

  // ------------------------------------------------------------
  // Stage wiring
  // ------------------------------------------------------------
  uopPkg::uopKind_e     kind;         // Class of the decode instruction
  uopPkg::instrFields_t fields;       // Sliced fields and register count
  uopPkg::seqState_e    state;        // Sequencer step
  logic                 listLoad;     // Walker takes the register list
  logic                 listAdvance;  // Walker drops the transferred register
  logic [3:0]           curReg;       // Next register to transfer
  logic                 lastReg;      // Final register of the list

  instrClassifier classifier (
    .instr  (instr),
    .kind   (kind),
    .fields (fields)
  );

  regListWalker walker (
    .clk         (clk),
    .reset       (reset),
    .regList     (fields.regList),
    .listLoad    (listLoad),
    .listAdvance (listAdvance),
    .curReg      (curReg),
    .lastReg     (lastReg)
  );

  uopSequencer sequencer (
    .clk             (clk),
    .reset           (reset),
    .stall           (stall),
    .exceptionSavePC (exceptionSavePC),
    .kind            (kind),
    .fields          (fields),
    .lastReg         (lastReg),
    .state           (state),
    .listLoad        (listLoad),
    .listAdvance     (listAdvance)
  );

  uopEncoder encoder (
    .state           (state),
    .kind            (kind),
    .fields          (fields),
    .curReg          (curReg),
    .lastReg         (lastReg),
    .exceptionSavePC (exceptionSavePC),
    .instr           (instr),
    .uopInstr        (uopInstr),
    .ctrl            (ctrl)
  );

endmodule

`default_nettype wire

//--- sim/microOpUnit_chk.sv
`timescale 1ns/1ps
`default_nettype none

module microOpUnit_chk (
  input wire logic             clk,
  input wire logic             reset,
  input wire logic [31:0]      instr,
  input wire logic             stall,
  input wire logic             exceptionSavePC,
  input wire logic [31:0]      uopInstr,
  input wire uopPkg::uopCtrl_t ctrl
);

  logic [4:0] blockDone;  // Transfers already issued for this block instruction
  logic       lastNoWb;   // Final transfer of a list without base update

  // ------------------------------------------------------------
  // Transfer count, kept apart from the walker
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset || !ctrl.ldmStmForward) begin
      blockDone <= '0;              // SUB step clears it before the transfers
    end else if (!stall) begin
      blockDone <= blockDone + 5'd1;
    end
  end

  assign lastNoWb = (int'(blockDone) + 1 == $countones(instr[15:0])) && !instr[21];

  // Decode only holds on a substituted word
  stallNeedsMux: assert property (@(posedge clk) disable iff (reset)
    ctrl.uopStall |-> ctrl.instrMux)
    else $error("uopStall high with instrMux low");

  // Block step ends the sequence only on the last register without writeback
  forwardStalls: assert property (@(posedge clk) disable iff (reset)
    ctrl.ldmStmForward |-> ctrl.uopStall || lastNoWb)
    else $error("ldmStmForward step released decode early");

  // Exception return load of r15 uses the current bank
  cpsrOnBlock: assert property (@(posedge clk) disable iff (reset)
    ctrl.cpsrRestore |-> ctrl.ldmStmForward && !ctrl.regUsr)
    else $error("cpsrRestore outside a banked block transfer");

  // External stall freezes the step
  stallHolds: assert property (@(posedge clk) disable iff (reset)
    $past(stall) && $stable(instr) && $stable(exceptionSavePC) |-> $stable(uopInstr))
    else $error("uopInstr changed under stall");

endmodule

bind microOpUnit microOpUnit_chk chk (
  .clk             (clk),
  .reset           (reset),
  .instr           (instr),
  .stall           (stall),
  .exceptionSavePC (exceptionSavePC),
  .uopInstr        (uopInstr),
  .ctrl            (ctrl)
);

`default_nettype wire

//--- sim/microOpUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module microOpUnitTb;

  localparam int itemCount  = 400;  // Instructions per run
  localparam int cycleLimit = 200;  // Cycles allowed for one instruction

  typedef struct packed {
    logic [31:0]      word;  // Expected uopInstr
    uopPkg::uopCtrl_t ctrl;  // Expected controls
  } step_t;

  logic             clk;
  logic             reset;
  logic [31:0]      instr;
  logic             stall;
  logic             exceptionSavePC;
  logic [31:0]      uopInstr;
  uopPkg::uopCtrl_t ctrl;

  logic [31:0] rngState;  // Xorshift state
  step_t       expSteps[$];  // Step list of the current instruction
  int          errors;
  int          checks;
  logic        timedOut;

  microOpUnit dut (
    .clk             (clk),
    .reset           (reset),
    .instr           (instr),
    .stall           (stall),
    .exceptionSavePC (exceptionSavePC),
    .uopInstr        (uopInstr),
    .ctrl            (ctrl)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] nextRand();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  function automatic int popCount(input logic [15:0] v);
    int n;
    n = 0;
    for (int i = 0; i < 16; i++) begin
      n = n + int'(v[i]);
    end
    return n;
  endfunction

  function automatic uopPkg::uopCtrl_t makeCtrl(input logic mux, input logic stl,
      input logic fwd, input logic usr, input logic cpsr, input logic rsr,
      input logic [2:0] rz);
    uopPkg::uopCtrl_t c;
    c.instrMux      = mux;
    c.uopStall      = stl;
    c.ldmStmForward = fwd;
    c.regUsr        = usr;
    c.cpsrRestore   = cpsr;
    c.prevRsr       = rsr;
    c.regFileRz     = rz;
    return c;
  endfunction

  function automatic uopPkg::uopKind_e modelKind(input logic [31:0] w);
    if (w[27:23] == 5'b00010 && w[21:20] == 2'b00 && w[7:4] == 4'b1001) begin
      return uopPkg::kindSwp;
    end
    if (w[27:25] == 3'b000 && !w[7] && w[4] && !(w[24:23] == 2'b10 && !w[20])) begin
      return uopPkg::kindRsr;  // Misc space excluded
    end
    if (w[27:25] == 3'b100 && w[15:0] != 16'd0) begin
      return uopPkg::kindBlock;
    end
    if (w[27:24] == 4'b1011) begin
      return uopPkg::kindBl;
    end
    return uopPkg::kindPlain;
  endfunction

  task automatic addStep(input logic [31:0] word, input uopPkg::uopCtrl_t c);
    step_t s;
    s.word = word;
    s.ctrl = c;
    expSteps.push_back(s);
  endtask

  // ------------------------------------------------------------
  // Reference model, one entry per expected step
  // ------------------------------------------------------------
  task automatic expandSteps(input logic [31:0] w, input logic exc);
    logic [31:0] cond;
    logic [31:0] rnF;
    logic [7:0]  n4;
    logic [7:0]  start;
    logic        usr;
    logic        ld;
    int          left;
    expSteps.delete();
    cond  = {w[31:28], 28'd0};
    rnF   = {12'd0, w[19:16], 16'd0};  // Rn in the Rn field
    n4    = 8'(popCount(w[15:0]) * 4);
    usr   = w[22];
    ld    = w[20];
    left  = popCount(w[15:0]);
    start = 8'd0;
    if (exc) begin
      addStep(32'hE1A0E00F, makeCtrl(1, 0, 0, 0, 0, 0, 3'b000));  // mov r14, pc
    end else begin
      case (modelKind(w))
        uopPkg::kindRsr: begin
          addStep(cond | 32'h01A0F000 | {20'd0, w[11:0]}, makeCtrl(1, 1, 0, 0, 0, 0, 3'b101));
          addStep({w[31:12], 12'h00F}, makeCtrl(1, 0, 0, 0, 0, 1, 3'b010));
        end
        uopPkg::kindBl: begin
          addStep(cond | 32'h024FE004, makeCtrl(1, 1, 0, 0, 0, 0, 3'b000));
          addStep(w & 32'hFEFFFFFF, makeCtrl(1, 0, 0, 0, 0, 0, 3'b000));
        end
        uopPkg::kindSwp: begin
          addStep(cond | 32'h0590F000 | {9'd0, w[22], 22'd0} | rnF,
                  makeCtrl(1, 1, 0, 0, 0, 0, 3'b100));
          addStep(cond | 32'h05800000 | {9'd0, w[22], 22'd0} | rnF | {16'd0, w[3:0], 12'd0},
                  makeCtrl(1, 1, 0, 0, 0, 0, 3'b000));
          addStep(cond | 32'h01A0000F | {16'd0, w[15:12], 12'd0},
                  makeCtrl(1, 0, 0, 0, 0, 0, 3'b010));
        end
        uopPkg::kindBlock: begin
          case ({w[24], w[23]})
            2'b00:   start = n4;          // DA
            2'b01:   start = 8'd4;        // IA
            2'b10:   start = n4 + 8'd4;   // DB
            default: start = 8'd0;        // IB
          endcase
          addStep(cond | 32'h0240F000 | rnF | {24'd0, start},
                  makeCtrl(1, 1, 0, 0, 0, 0, 3'b100));
          for (int r = 0; r < 16; r++) begin
            if (w[r]) begin
              addStep(cond | 32'h05AF0004 | {11'd0, ld, 20'd0} | {16'd0, 4'(r), 12'd0},
                      makeCtrl(1, !(left == 1 && !w[21]), 1, usr && (!ld || !w[15]),
                               usr && ld && r == 15, 0, 3'b001));
              left = left - 1;
            end
          end
          if (w[21]) begin
            addStep(cond | 32'h02000000 | (w[23] ? 32'h00800000 : 32'h00400000) | rnF
                    | {16'd0, w[19:16], 12'd0} | {24'd0, n4},
                    makeCtrl(1, 0, 0, 0, 0, 0, 3'b000));
          end
        end
        default: addStep(w, makeCtrl(0, 0, 0, 0, 0, 0, 3'b000));  // Pass-through
      endcase
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus and checks
  // ------------------------------------------------------------
  task automatic pickInstr(output logic [31:0] w, output logic exc);
    logic [31:0] r;
    logic [31:0] m;
    logic [31:0] sel;
    r   = nextRand();
    m   = nextRand();
    sel = nextRand() % 6;
    exc = 1'b0;
    w   = r;
    case (sel)
      1: w = {r[31:28], 3'b000, r[24:8], 1'b0, r[6:5], 1'b1, r[3:0]};       // RSR shape
      2: w = {r[31:28], 4'b1011, r[23:0]};                                   // BL
      3: w = {r[31:28], 5'b00010, r[22], 2'b00, r[19:8], 4'b1001, r[3:0]};  // SWP
      4: w = {r[31:28], 3'b100, r[24:16], m[31] ? r[15:0] & m[15:0] : r[15:0]};
      5: exc = 1'b1;
      default: w = r;  // Mostly plain
    endcase
  endtask

  task automatic checkStep(input step_t exp);
    checks++;
    if (uopInstr !== exp.word) begin
      errors++;
      $display("CHECK FAILED uopInstr got %h expected %h (instr %h)", uopInstr, exp.word, instr);
    end
    if (ctrl !== exp.ctrl) begin
      errors++;
      $display("CHECK FAILED ctrl got %h expected %h (instr %h)", ctrl, exp.ctrl, instr);
    end
  endtask

  task automatic runItem(input logic [31:0] w, input logic exc);
    int          idx;
    int          cycles;
    logic        done;
    logic [31:0] r;
    expandSteps(w, exc);
    idx             = 0;
    cycles          = 0;
    done            = 1'b0;
    instr           = w;
    exceptionSavePC = exc;
    while (!done && cycles < cycleLimit) begin  // Until uopStall falls on a live cycle
      r     = nextRand();
      stall = (r[1:0] == 2'b00);   // About one cycle in four
      #1;
      if (idx < expSteps.size()) begin
        checkStep(expSteps[idx]);  // Outputs repeat while stalled
      end
      if (!stall) begin
        idx++;
        done = !ctrl.uopStall;     // Decode released
      end
      cycles++;
      @(posedge clk);
      #1;
    end
    if (!done) begin
      errors++;
      timedOut = 1'b1;
      $display("Timeout: instr %h kept decode stalled for %0d cycles", w, cycleLimit);
    end else if (idx != expSteps.size()) begin
      errors++;
      $display("Step count wrong: instr %h took %0d steps, expected %0d", w, idx,
               expSteps.size());
    end
    stall           = 1'b0;
    exceptionSavePC = 1'b0;
  endtask

  initial begin
    logic [31:0] w;
    logic        exc;
    rngState        = 32'd3532;
    errors          = 0;
    checks          = 0;
    timedOut        = 1'b0;
    instr           = '0;
    stall           = 1'b0;
    exceptionSavePC = 1'b0;
    reset           = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < itemCount && !timedOut; i++) begin
      pickInstr(w, exc);
      runItem(w, exc);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
src/uopPkg.sv
src/instrClassifier.sv
src/regListWalker.sv
src/uopSequencer.sv
src/uopEncoder.sv
src/microOpUnit.sv
sim/microOpUnit_chk.sv
sim/microOpUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the microOpUnit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module microOpUnitTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/simv)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "test passed"; then
  exit 0
fi
exit 1
